//--- chien_top.f
rtl/gf_pkg.sv
rtl/chien_pkg.sv
rtl/chien_ctrl.sv
rtl/chien_sigma_step.sv
rtl/chien_pe_array.sv
rtl/chien_loc_collect.sv
rtl/chien_top.sv
bench/tb_clk_gen.sv
bench/tb_chien_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the chien_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_chien_top -f chien_top.f --Mdir obj_dir

./obj_dir/Vtb_chien_top | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- bench/tb_chien_top.sv
`timescale 1ns/1ns

module tb_chien_top;

    import gf_pkg::*;
    import chien_pkg::*;

    localparam int tdrv = 2;                    // drive point after the rising edge

    logic       clk;
    logic       rst_n;
    logic       req;
    logic       ack;
    logic       res_req;
    logic       res_ack;
    logic       corr_in;
    logic       corr_out;
    gf_elem_t   sig0;
    gf_elem_t   sig1;
    gf_elem_t   sig2;
    chien_cnt_t degree;
    chien_cnt_t num_err;
    chien_cnt_t got_num;
    chien_loc_t loc0;
    chien_loc_t loc1;
    chien_loc_t got_loc0;
    chien_loc_t got_loc1;
    logic       got_corr;
    int         got_lat;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         tests_failed = 0;
    gf_elem_t   exp_tab [gf_n];                 // alpha^i
    int         log_tab [1 << gf_m];
    event       abort_run;

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    chien_top uut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_req      (req),
        .o_ack      (ack),
        .i_sigma0   (sig0),
        .i_sigma1   (sig1),
        .i_sigma2   (sig2),
        .i_degree   (degree),
        .i_correct  (corr_in),
        .o_res_req  (res_req),
        .i_res_ack  (res_ack),
        .o_err_loc0 (loc0),
        .o_err_loc1 (loc1),
        .o_num_err  (num_err),
        .o_correct  (corr_out)
    );

    // ------------------------------------------------------------------------
    // reference model on log/antilog tables
    // ------------------------------------------------------------------------
    function automatic void build_tables();
        logic [gf_m:0] w;
        w = '0;
        w[0] = 1'b1;
        for (int i = 0; i < gf_n; i++) begin
            exp_tab[i] = w[gf_m-1:0];
            log_tab[w[gf_m-1:0]] = i;
            w = {w[gf_m-1:0], 1'b0};
            if (w[gf_m]) begin
                w = w ^ gf_prim_poly;
            end
        end
    endfunction

    function automatic gf_elem_t apow(int e);
        return exp_tab[((e % gf_n) + gf_n) % gf_n];
    endfunction

    function automatic gf_elem_t gmul(gf_elem_t a, gf_elem_t b);
        if (a == '0 || b == '0) begin
            return '0;
        end
        return exp_tab[(log_tab[a] + log_tab[b]) % gf_n];
    endfunction

    // sigma(x) = prod (1 + alpha^l x) with b < 0 for a single error
    task automatic build_sigma(input int a, b, output gf_elem_t s0, s1, s2);
        s0 = gf_elem_t'(1);
        s1 = (b < 0) ? apow(a) : apow(a) ^ apow(b);
        s2 = (b < 0) ? '0 : gmul(apow(a), apow(b));
    endtask

    // roots at alpha^-i and the first two of them
    task automatic predict(input gf_elem_t s0, s1, s2, output int e0, e1, en);
        int found;
        found = 0;
        e0 = 0;
        e1 = 0;
        for (int i = 0; i < gf_n; i++) begin
            if ((s0 ^ gmul(s1, apow(-i)) ^ gmul(s2, apow(-2 * i))) == '0) begin
                e0 = (found == 0) ? i : e0;
                e1 = (found == 1) ? i : e1;
                found++;
            end
        end
        en = (found > chien_max_err) ? chien_max_err + 1 : found;   // saturates
    endtask

    // ------------------------------------------------------------------------
    // checks and handshakes
    // ------------------------------------------------------------------------
    task automatic check_val(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    // poll o_ack (0), o_res_req (1) or reset release (2) once per cycle
    task automatic wait_for(input int sel, input logic level, input int limit, output int n);
        string      names [3] = '{"o_ack", "o_res_req", "reset release"};
        logic [2:0] now;
        n = 0;
        now = {rst_n, res_req, ack};
        while (now[sel] !== level) begin
            @(posedge clk);
            #tdrv;
            now = {rst_n, res_req, ack};
            n++;
            if (n > limit) begin
                $display("timeout: %s did not reach %0b within %0d cycles",
                         names[sel], level, limit);
                -> abort_run;
                @(posedge clk);
            end
        end
    endtask

    task automatic send_request(input gf_elem_t s0, s1, s2, input chien_cnt_t deg,
                                input logic c);
        int n_ack;
        int n_drop;
        int n_res;
        sig0 = s0;
        sig1 = s1;
        sig2 = s2;
        degree = deg;
        corr_in = c;
        req = 1'b1;
        wait_for(0, 1'b1, 30, n_ack);
        req = 1'b0;
        wait_for(0, 1'b0, 4, n_drop);
        wait_for(1, 1'b1, 12, n_res);
        got_lat = n_drop + n_res;               // edges after o_ack rose
        got_loc0 = loc0;
        got_loc1 = loc1;
        got_num = num_err;
        got_corr = corr_out;
    endtask

    // result must stay put and no request is taken while i_res_ack is high or low
    task automatic take_result(input int hold);
        int n;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #tdrv;
            check_val("o_res_req", int'(res_req), 1);
            check_val("o_ack", int'(ack), 0);
            check_val("o_err_loc0", int'(loc0), int'(got_loc0));
            check_val("o_err_loc1", int'(loc1), int'(got_loc1));
            check_val("o_num_err", int'(num_err), int'(got_num));
            check_val("o_correct", int'(corr_out), int'(got_corr));
        end
        res_ack = 1'b1;
        wait_for(1, 1'b0, 4, n);
        check_val("o_ack", int'(ack), 0);
        @(posedge clk);                         // i_res_ack still high for one edge
        #tdrv;
        check_val("o_ack", int'(ack), 0);
        res_ack = 1'b0;
    endtask

    task automatic check_result(input int e0, e1, en, input logic ec);
        check_val("latency", got_lat, 6);
        check_val("o_err_loc0", int'(got_loc0), e0);
        check_val("o_err_loc1", int'(got_loc1), e1);
        check_val("o_num_err", int'(got_num), en);
        check_val("o_correct", int'(got_corr), int'(ec));
    endtask

    task automatic run_case(input gf_elem_t s0, s1, s2, input chien_cnt_t deg, input logic c,
                            input int e0, e1, en, input logic ec);
        send_request(s0, s1, s2, deg, c);
        take_result(0);
        check_result(e0, e1, en, ec);
    endtask

    task automatic report(input string name, input int e);
        tests++;
        tests_failed += (errors != e) ? 1 : 0;
        $display("test %s %s", name, (errors == e) ? "passed" : "failed");
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic handshake_timing();
        int       e;
        int       n;
        gf_elem_t s0, s1, s2;
        e = errors;
        wait_for(2, 1'b1, 20, n);
        @(posedge clk);
        #tdrv;
        check_val("o_ack", int'(ack), 0);
        check_val("o_res_req", int'(res_req), 0);
        check_val("o_num_err", int'(num_err), 0);
        build_sigma(5, -1, s0, s1, s2);
        run_case(s0, s1, s2, 2'd1, 1'b1, 5, 0, 1, 1'b1);
        report("handshake", e);
    endtask

    task automatic error_locations();
        int       loc_a [9] = '{0, 62, 0, 3, 15, 20, 33, 48, 40};
        int       loc_b [9] = '{-1, -1, 62, 9, 16, 47, 34, 62, 7};   // -1 single
        int       e;
        int       lo;
        int       hi;
        gf_elem_t s0, s1, s2;
        e = errors;
        for (int i = 0; i < 9; i++) begin
            build_sigma(loc_a[i], loc_b[i], s0, s1, s2);
            if (loc_b[i] < 0) begin
                run_case(s0, s1, s2, 2'd1, 1'b1, loc_a[i], 0, 1, 1'b1);
            end else begin
                lo = (loc_a[i] < loc_b[i]) ? loc_a[i] : loc_b[i];
                hi = (loc_a[i] < loc_b[i]) ? loc_b[i] : loc_a[i];
                run_case(s0, s1, s2, 2'd2, 1'b1, lo, hi, 2, 1'b1);
            end
        end
        report("locations", e);
    endtask

    task automatic correct_flag_cases();
        int       e;
        gf_elem_t s0, s1, s2;
        e = errors;
        run_case(gf_elem_t'(1), '0, '0, 2'd0, 1'b1, 0, 0, 0, 1'b1);
        run_case(gf_elem_t'(1), '0, '0, 2'd0, 1'b0, 0, 0, 0, 1'b0);
        run_case('0, '0, '0, 2'd2, 1'b1, 0, 1, 3, 1'b0);   // every position a root
        build_sigma(7, 40, s0, s1, s2);
        run_case(s0, s1, s2, 2'd1, 1'b1, 7, 40, 2, 1'b0);
        run_case(s0, s1, s2, 2'd2, 1'b0, 7, 40, 2, 1'b0);
        build_sigma(12, -1, s0, s1, s2);
        run_case(s0, s1, s2, 2'd2, 1'b1, 12, 0, 1, 1'b0);
        report("correct flag", e);
    endtask

    task automatic result_backpressure();
        int       e;
        gf_elem_t s0, s1, s2;
        e = errors;
        for (int r = 0; r < 3; r++) begin
            build_sigma(r, 40 + r, s0, s1, s2);
            send_request(s0, s1, s2, 2'd2, 1'b1);
            build_sigma(10 + r, -1, s0, s1, s2);
            sig0 = s0;
            sig1 = s1;
            sig2 = s2;
            degree = 2'd1;
            req = 1'b1;                         // queued behind the open result
            take_result($urandom_range(20));
            check_result(r, 40 + r, 2, 1'b1);
            run_case(s0, s1, s2, 2'd1, 1'b1, 10 + r, 0, 1, 1'b1);
        end
        report("back-pressure", e);
    endtask

    task automatic random_pairs();
        int       e;
        int       a;
        int       b;
        int       e0;
        int       e1;
        int       en;
        gf_elem_t s0, s1, s2;
        e = errors;
        for (int i = 0; i < 20; i++) begin
            a = $urandom_range(gf_n - 1);
            b = (a + 1 + $urandom_range(gf_n - 2)) % gf_n;   // never equal to a
            build_sigma(a, b, s0, s1, s2);
            predict(s0, s1, s2, e0, e1, en);
            run_case(s0, s1, s2, 2'd2, 1'b1, e0, e1, en, en == 2);
        end
        report("random", e);
    endtask

    initial begin
        @(abort_run);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        req = 1'b0;
        res_ack = 1'b0;
        sig0 = '0;
        sig1 = '0;
        sig2 = '0;
        degree = '0;
        corr_in = 1'b0;
        void'($urandom(82152));
        build_tables();
        handshake_timing();
        error_locations();
        correct_flag_cases();
        result_backpressure();
        random_pairs();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(period_ns / 2) o_clk = ~o_clk;
        end
    end

    // sync reset, released just after an edge
    initial begin
        o_rst_n = 1'b0;
        repeat (rst_cycles) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- rtl/chien_top.sv
`timescale 1ns/1ns

module chien_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    // locator polynomial in
    input  logic                   i_req,
    output logic                   o_ack,
    input  gf_pkg::gf_elem_t       i_sigma0,
    input  gf_pkg::gf_elem_t       i_sigma1,
    input  gf_pkg::gf_elem_t       i_sigma2,
    input  chien_pkg::chien_cnt_t  i_degree,
    input  logic                   i_correct,

    // result out
    output logic                   o_res_req,
    input  logic                   i_res_ack,
    output chien_pkg::chien_loc_t  o_err_loc0,
    output chien_pkg::chien_loc_t  o_err_loc1,
    output chien_pkg::chien_cnt_t  o_num_err,
    output logic                   o_correct
);

    import gf_pkg::*;
    import chien_pkg::*;

    logic                   load;
    chien_seg_t             seg;
    logic                   seg_vld;
    gf_elem_t               sigma0;
    gf_elem_t               term1;
    gf_elem_t               term2;
    logic [chien_lanes-1:0] roots;
    chien_seg_t             roots_seg;
    logic                   roots_vld;

    chien_ctrl u_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .o_ack      (o_ack),
        .o_res_req  (o_res_req),
        .i_res_ack  (i_res_ack),
        .o_load     (load),
        .o_seg      (seg),
        .o_seg_vld  (seg_vld)
    );

    chien_sigma_step u_sigma_step (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_load     (load),
        .i_seg_vld  (seg_vld),
        .i_sigma0   (i_sigma0),
        .i_sigma1   (i_sigma1),
        .i_sigma2   (i_sigma2),
        .o_sigma0   (sigma0),
        .o_term1    (term1),
        .o_term2    (term2)
    );

    chien_pe_array u_pe_array (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_seg      (seg),
        .i_seg_vld  (seg_vld),
        .i_sigma0   (sigma0),
        .i_term1    (term1),
        .i_term2    (term2),
        .o_roots    (roots),
        .o_seg      (roots_seg),
        .o_seg_vld  (roots_vld)
    );

    chien_loc_collect u_loc_collect (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_load     (load),
        .i_roots    (roots),
        .i_seg      (roots_seg),
        .i_seg_vld  (roots_vld),
        .i_degree   (i_degree),
        .i_correct  (i_correct),
        .o_err_loc0 (o_err_loc0),
        .o_err_loc1 (o_err_loc1),
        .o_num_err  (o_num_err),
        .o_correct  (o_correct)
    );

endmodule

//--- rtl/chien_loc_collect.sv
`timescale 1ns/1ns

module chien_loc_collect (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    input  logic                            i_load,
    input  logic [chien_pkg::chien_lanes-1:0] i_roots,
    input  chien_pkg::chien_seg_t           i_seg,
    input  logic                            i_seg_vld,
    input  chien_pkg::chien_cnt_t           i_degree,
    input  logic                            i_correct,

    output chien_pkg::chien_loc_t           o_err_loc0,
    output chien_pkg::chien_loc_t           o_err_loc1,
    output chien_pkg::chien_cnt_t           o_num_err,
    output logic                            o_correct
);

    import chien_pkg::*;

    localparam chien_cnt_t cnt_sat = chien_cnt_t'(chien_max_err + 1);

    logic                    first_hit;
    logic                    second_hit;
    logic [chien_lane_w-1:0] first_lane;
    logic [chien_lane_w-1:0] second_lane;
    logic [chien_lane_w:0]   hits;          // 0..16
    logic [chien_lane_w+1:0] total;
    chien_cnt_t              cnt_next;
    chien_loc_t              loc_first;
    chien_loc_t              loc_second;
    chien_cnt_t              degree_q;
    logic                    correct_q;

    // ------------------------------------------------------------------------
    // find first ones
    // ------------------------------------------------------------------------
    always_comb begin
        first_hit   = 1'b0;
        second_hit  = 1'b0;
        first_lane  = '0;
        second_lane = '0;
        hits        = '0;
        for (int k = 0; k < chien_lanes; k++) begin
            if (i_roots[k]) begin
                if (!first_hit) begin
                    first_hit  = 1'b1;
                    first_lane = k[chien_lane_w-1:0];
                end else if (!second_hit) begin
                    second_hit  = 1'b1;
                    second_lane = k[chien_lane_w-1:0];
                end
                hits = hits + 1'b1;
            end
        end
    end

    assign loc_first  = chien_loc_t'({i_seg, first_lane});     // 16 s + k
    assign loc_second = chien_loc_t'({i_seg, second_lane});

    // saturating root count
    assign total    = {{chien_lane_w{1'b0}}, o_num_err} + {1'b0, hits};
    assign cnt_next = (total > {{chien_lane_w{1'b0}}, cnt_sat}) ? cnt_sat : total[1:0];

    // ------------------------------------------------------------------------
    // merge into the running list
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_err_loc0 <= '0;
            o_err_loc1 <= '0;
            o_num_err  <= '0;
            degree_q   <= '0;
            correct_q  <= 1'b0;
        end else if (i_load) begin
            o_err_loc0 <= '0;
            o_err_loc1 <= '0;
            o_num_err  <= '0;
            degree_q   <= i_degree;
            correct_q  <= i_correct;
        end else if (i_seg_vld) begin
            if (o_num_err == 2'd0) begin
                if (first_hit) begin
                    o_err_loc0 <= loc_first;
                end
                if (second_hit) begin
                    o_err_loc1 <= loc_second;
                end
            end else if (o_num_err == 2'd1 && first_hit) begin
                o_err_loc1 <= loc_first;      // one slot left
            end
            o_num_err <= cnt_next;
        end
    end

    // roots found must match the declared degree
    assign o_correct = correct_q && (o_num_err != cnt_sat) && (o_num_err == degree_q);

    a_count_monotonic : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$past(i_load) |-> o_num_err >= $past(o_num_err));

endmodule

//--- rtl/chien_pe_array.sv
`timescale 1ns/1ns

module chien_pe_array (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    input  chien_pkg::chien_seg_t           i_seg,
    input  logic                            i_seg_vld,
    input  gf_pkg::gf_elem_t                i_sigma0,
    input  gf_pkg::gf_elem_t                i_term1,
    input  gf_pkg::gf_elem_t                i_term2,

    output logic [chien_pkg::chien_lanes-1:0] o_roots,
    output chien_pkg::chien_seg_t           o_seg,
    output logic                            o_seg_vld
);

    import gf_pkg::*;
    import chien_pkg::*;

    logic [chien_lanes-1:0] hit;
    logic [chien_lanes-1:0] roots_d;

    // lanes whose position lies inside the code
    function automatic logic [chien_lanes-1:0] lane_mask(chien_seg_t seg);
        logic [chien_lanes-1:0] m;
        for (int k = 0; k < chien_lanes; k++) begin
            m[k] = (int'(seg) * chien_lanes + k) < gf_n;
        end
        return m;
    endfunction

    // ------------------------------------------------------------------------
    // root test per lane, sigma(alpha^-(16 s + k)) == 0
    // ------------------------------------------------------------------------
    for (genvar k = 0; k < chien_lanes; k++) begin : g_lane
        localparam gf_elem_t a1 = gf_pow(-k);
        localparam gf_elem_t a2 = gf_pow(-2 * k);
        gf_elem_t eval;

        assign eval   = i_sigma0 ^ gf_mul(i_term1, a1) ^ gf_mul(i_term2, a2);
        assign hit[k] = (eval == '0);
    end

    assign roots_d = hit & lane_mask(i_seg);   // position 63 is not a symbol

    always_ff @(posedge i_clk) begin
        o_roots <= roots_d;
        o_seg   <= i_seg;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_seg_vld <= 1'b0;
        end else begin
            o_seg_vld <= i_seg_vld;
        end
    end

    // nothing at or past position 63
    a_no_masked_root : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_seg_vld |-> ((o_roots >> (gf_n - int'(o_seg) * chien_lanes)) == '0));

endmodule

//--- rtl/chien_sigma_step.sv
`timescale 1ns/1ns

module chien_sigma_step (
    input  logic               i_clk,
    input  logic               i_rst_n,

    input  logic               i_load,
    input  logic               i_seg_vld,

    input  gf_pkg::gf_elem_t   i_sigma0,
    input  gf_pkg::gf_elem_t   i_sigma1,
    input  gf_pkg::gf_elem_t   i_sigma2,

    output gf_pkg::gf_elem_t   o_sigma0,
    output gf_pkg::gf_elem_t   o_term1,
    output gf_pkg::gf_elem_t   o_term2
);

    import gf_pkg::*;
    import chien_pkg::*;

    // term j advances by alpha^(-16 j) per segment
    localparam gf_elem_t step1 = gf_pow(-chien_lanes);
    localparam gf_elem_t step2 = gf_pow(-2 * chien_lanes);

    gf_elem_t sigma0_q;
    gf_elem_t term1_q;
    gf_elem_t term2_q;

    // ------------------------------------------------------------------------
    // coefficient registers
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sigma0_q <= '0;
            term1_q  <= '0;
            term2_q  <= '0;
        end else if (i_load) begin
            sigma0_q <= i_sigma0;
            term1_q  <= i_sigma1;
            term2_q  <= i_sigma2;
        end else if (i_seg_vld) begin
            // sigma0 has no x term, stays as loaded
            term1_q <= gf_mul(term1_q, step1);
            term2_q <= gf_mul(term2_q, step2);
        end
    end

    assign o_sigma0 = sigma0_q;
    assign o_term1  = term1_q;     // sigma1 * alpha^(-16 s)
    assign o_term2  = term2_q;     // sigma2 * alpha^(-32 s)

endmodule

//--- rtl/chien_ctrl.sv
`timescale 1ns/1ns

module chien_ctrl (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    input  logic                   i_req,
    output logic                   o_ack,

    output logic                   o_res_req,
    input  logic                   i_res_ack,

    output logic                   o_load,
    output chien_pkg::chien_seg_t  o_seg,
    output logic                   o_seg_vld
);

    import chien_pkg::*;

    localparam int cnt_w = $clog2(chien_segs + chien_pipe_depth);
    localparam logic [cnt_w-1:0] cnt_segs = cnt_w'(chien_segs);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(chien_segs + chien_pipe_depth - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_search,
        st_wait
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] seg_cnt;
    logic             accept;

    // new request only once the previous handshakes are closed
    assign accept = (state == st_idle) && i_req && !o_ack && !i_res_ack;

    assign o_load    = accept;
    assign o_seg     = seg_cnt[$bits(chien_seg_t)-1:0];
    assign o_seg_vld = (state == st_search) && (seg_cnt < cnt_segs);

    // ------------------------------------------------------------------------
    // state machine and segment counter
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= st_idle;
            seg_cnt   <= '0;
            o_res_req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state   <= st_search;
                        seg_cnt <= '0;
                    end
                end
                st_search: begin
                    if (seg_cnt == cnt_last) begin   // pipeline drained
                        state     <= st_wait;
                        o_res_req <= 1'b1;
                    end else begin
                        seg_cnt <= seg_cnt + 1'b1;
                    end
                end
                st_wait: begin
                    if (i_res_ack) begin
                        state     <= st_idle;
                        o_res_req <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // input handshake
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else if (accept) begin
            o_ack <= 1'b1;
        end else if (!i_req) begin
            o_ack <= 1'b0;
        end
    end

    a_ack_needs_req : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_ack) |-> $past(i_req));

    // result only after the segments and both pipeline stages
    a_res_after_segs : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_res_req) |-> !$past(o_seg_vld) && !$past(o_seg_vld, 2));

endmodule

//--- rtl/chien_pkg.sv
package chien_pkg;

    // ------------------------------------------------------------------------
    // search geometry
    // ------------------------------------------------------------------------
    localparam int chien_lanes = 16;                   // positions per segment
    localparam int chien_segs = 4;                     // 4 x 16 covers 63
    localparam int chien_max_err = 2;
    localparam int chien_lane_w = $clog2(chien_lanes);
    localparam int chien_pipe_depth = 2;               // pe array + collector

    // location 0..62
    typedef logic [5:0] chien_loc_t;

    typedef logic [1:0] chien_seg_t;

    // 3 means more roots than chien_max_err
    typedef logic [1:0] chien_cnt_t;

endpackage

//--- rtl/gf_pkg.sv
package gf_pkg;

    // ------------------------------------------------------------------------
    // GF(2^6) for the BCH(63,51) code
    // ------------------------------------------------------------------------
    localparam int gf_m = 6;
    localparam int gf_n = 63;                          // 2^m - 1
    localparam logic [gf_m:0] gf_prim_poly = 7'b1000011;   // x^6 + x + 1

    typedef logic [gf_m-1:0] gf_elem_t;

    // shift and add, msb of b first
    function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
        gf_elem_t p;
        logic     msb;
        p = '0;
        for (int i = gf_m - 1; i >= 0; i--) begin
            msb = p[gf_m-1];
            p = {p[gf_m-2:0], 1'b0};
            if (msb) begin
                p = p ^ gf_prim_poly[gf_m-1:0];    // reduce
            end
            if (b[i]) begin
                p = p ^ a;
            end
        end
        return p;
    endfunction

    // alpha^e, negative powers wrap modulo n
    function automatic gf_elem_t gf_pow(int e);
        gf_elem_t r;
        int       k;
        r = gf_elem_t'(1);
        k = e % gf_n;
        if (k < 0) begin
            k = k + gf_n;
        end
        for (int i = 0; i < k; i++) begin
            r = gf_mul(r, gf_elem_t'(2));   // alpha = x
        end
        return r;
    endfunction

endpackage
